// File: include/uart_rx_memory_map.svh
`ifndef UART_RX_MEMORY_MAP_SVH
`define UART_RX_MEMORY_MAP_SVH

// Register offsets of the receive port as byte addresses
localparam logic [31:0] RX_TAIL_ADDR  = 32'h0000_0400;
localparam logic [31:0] RX_COUNT_ADDR = 32'h0000_0404;

// Every other address reads buffer word addr[9:2]

`endif

// File: design/mmio_uart_rx_pkg.sv
package mmio_uart_rx_pkg;

`include "uart_rx_memory_map.svh"

    // ----------------------------------------
    // Buffer geometry
    // ----------------------------------------
    localparam int RAM_WORDS = 256;

    typedef logic [7:0]  rx_byte_t;
    typedef logic [31:0] rx_word_t;
    typedef logic [9:0]  rx_tail_t;
    typedef logic [7:0]  ram_addr_t;

    // Last byte position before the tail rolls over
    localparam rx_tail_t TAIL_LAST = '1;

    // ----------------------------------------
    // Bus side
    // ----------------------------------------
    typedef struct packed {
        logic        start;
        logic [31:0] addr;
    } mmio_cmd_t;

    typedef struct packed {
        rx_word_t rdata;
        logic     rdata_valid;
    } mmio_rsp_t;

    // One byte-lane write into the buffer
    typedef struct packed {
        logic       en;
        ram_addr_t  addr;
        logic [1:0] lane;
        rx_byte_t   data;
    } ram_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_MEM,
        READ_WAIT,
        HELD_BYTE_READ
    } fsm_state_t;

endpackage

// File: design/baud_timer.sv
`timescale 1ns/1ps

module baud_timer #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic tick
);

    localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;

    // Reload values for a counter that ticks when it reaches zero
    localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(CLKS_PER_BIT / 2 - 1);

    logic [CNT_W-1:0] cnt;
    logic             running;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (restart) begin
            // Half a period puts the first tick in the middle of the start bit
            cnt     <= HALF_LOAD;
            running <= 1'b1;
        end else if (running) begin
            if (cnt == '0) begin
                cnt <= FULL_LOAD;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Keeps ticking at full periods until the next restart
    assign tick = running && (cnt == '0);

endmodule

// File: design/uart_rx_deserializer.sv
`timescale 1ns/1ps

module uart_rx_deserializer
    import mmio_uart_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     uart_rx,
    input  logic     tick,
    output logic     restart,
    output logic     byte_valid,
    output rx_byte_t byte_data
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    logic [2:0] bit_idx;
    rx_byte_t   shift_q;

    // ----------------------------------------
    // Line synchronizer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Falling edge while idle is a candidate start bit
    assign restart = (state == RX_IDLE) && rx_prev && !rx_sync;

    // ----------------------------------------
    // Frame sequencer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RX_IDLE;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (restart) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        // A line already back high was only a glitch
                        if (rx_sync) begin
                            state <= RX_IDLE;
                        end else begin
                            state   <= RX_DATA;
                            bit_idx <= '0;
                        end
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        byte_valid <= rx_sync;
                        state      <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so bits enter from the top
    always_ff @(posedge clk) begin
        if ((state == RX_DATA) && tick) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

    assign byte_data = shift_q;

endmodule

// File: design/rx_buffer_ram.sv
`timescale 1ns/1ps

module rx_buffer_ram
    import mmio_uart_rx_pkg::*;
(
    input  logic      clk,
    input  ram_wr_t   wr,
    input  ram_addr_t rd_addr,
    output rx_word_t  rd_data
);

    rx_word_t mem [0:RAM_WORDS-1];
    rx_word_t merged;

    // ----------------------------------------
    // Lane merge
    // ----------------------------------------
    // The FSM reads the tail word one cycle before it writes, so the
    // read register already holds the three lanes that must survive
    always_comb begin
        merged = rd_data;
        merged[{wr.lane, 3'b000} +: 8] = wr.data;
    end

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= merged;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// File: design/rx_buffer_fsm.sv
`timescale 1ns/1ps

module rx_buffer_fsm
    import mmio_uart_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      byte_valid,
    input  rx_byte_t  byte_data,
    input  mmio_cmd_t cmd,
    output logic      ready,
    output mmio_rsp_t rsp,
    output ram_wr_t   wr,
    output ram_addr_t rd_addr,
    input  rx_word_t  rd_data
);

    fsm_state_t state;
    rx_tail_t   tail;
    rx_word_t   wrap_count;
    rx_byte_t   byte_q;
    logic       sel_tail_q;
    logic       sel_count_q;
    rx_word_t   rsp_data_q;
    logic       rsp_valid_q;
    logic       accept;

    // A byte from the line wins over a command on the same cycle
    assign ready  = (state == IDLE) && !byte_valid;
    assign accept = cmd.start && ready;

    // Read port serves the command only when it is being accepted
    assign rd_addr = ready ? cmd.addr[9:2] : tail[9:2];

    assign wr = '{
        en:   (state == WRITE_MEM),
        addr: tail[9:2],
        lane: tail[1:0],
        data: byte_q
    };

    // ----------------------------------------
    // Control state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            tail        <= '0;
            wrap_count  <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (byte_valid) begin
                        state <= WRITE_MEM;
                    end else if (accept) begin
                        state <= READ_WAIT;
                    end
                end
                READ_WAIT: begin
                    // The response goes out even when a byte shows up now
                    rsp_valid_q <= 1'b1;
                    if (byte_valid) begin
                        state <= HELD_BYTE_READ;
                    end else begin
                        state <= IDLE;
                    end
                end
                HELD_BYTE_READ: begin
                    state <= WRITE_MEM;
                end
                WRITE_MEM: begin
                    tail <= tail + 1'b1;
                    if (tail == TAIL_LAST) begin
                        wrap_count <= wrap_count + 1'b1;
                    end
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Byte hold and response data
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (byte_valid && ((state == IDLE) || (state == READ_WAIT))) begin
            byte_q <= byte_data;
        end
        if (accept) begin
            sel_tail_q  <= (cmd.addr == RX_TAIL_ADDR);
            sel_count_q <= (cmd.addr == RX_COUNT_ADDR);
        end
        if (state == READ_WAIT) begin
            if (sel_tail_q) begin
                rsp_data_q <= {22'b0, tail};
            end else if (sel_count_q) begin
                rsp_data_q <= wrap_count;
            end else begin
                rsp_data_q <= rd_data;
            end
        end
    end

    assign rsp = '{rdata: rsp_data_q, rdata_valid: rsp_valid_q};

endmodule

// File: design/mmio_uart_rx.sv
`timescale 1ns/1ps

module mmio_uart_rx
    import mmio_uart_rx_pkg::*;
#(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      uart_rx,
    input  mmio_cmd_t cmd,
    output logic      ready,
    output mmio_rsp_t rsp
);

    logic      restart;
    logic      tick;
    logic      byte_valid;
    rx_byte_t  byte_data;
    ram_wr_t   wr;
    ram_addr_t rd_addr;
    rx_word_t  rd_data;

    // ----------------------------------------
    // Serial receive path
    // ----------------------------------------
    baud_timer #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_baud_timer (
        .clk     (clk),
        .rst     (rst),
        .restart (restart),
        .tick    (tick)
    );

    uart_rx_deserializer u_deserializer (
        .clk        (clk),
        .rst        (rst),
        .uart_rx    (uart_rx),
        .tick       (tick),
        .restart    (restart),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    // ----------------------------------------
    // Buffer and bus side
    // ----------------------------------------
    rx_buffer_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .cmd        (cmd),
        .ready      (ready),
        .rsp        (rsp),
        .wr         (wr),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    rx_buffer_ram u_ram (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: tests/rx_buffer_fsm_sva.sv
`timescale 1ns/1ps

module rx_buffer_fsm_sva
    import mmio_uart_rx_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input fsm_state_t state,
    input rx_tail_t   tail,
    input logic       accept,
    input mmio_rsp_t  rsp
);

    // A response is a single-cycle pulse
    valid_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        rsp.rdata_valid |-> !$past(rsp.rdata_valid)
    ) else $error("rdata_valid stayed high for two cycles");

    // Every accepted command answers exactly two cycles later
    read_latency: assert property (
        @(posedge clk) disable iff (rst)
        $past(accept, 2) |-> rsp.rdata_valid
    ) else $error("accepted command not answered two cycles later");

    valid_has_command: assert property (
        @(posedge clk) disable iff (rst)
        rsp.rdata_valid |-> $past(accept, 2)
    ) else $error("rdata_valid without a command two cycles before");

    // Tail moves by one byte, only out of WRITE_MEM
    tail_step: assert property (
        @(posedge clk) disable iff (rst)
        (tail != $past(tail)) || ($past(state) == WRITE_MEM) |->
            ($past(state) == WRITE_MEM) && (tail == rx_tail_t'($past(tail) + 1'b1))
    ) else $error("tail changed outside WRITE_MEM or by a step other than one");

endmodule

bind rx_buffer_fsm rx_buffer_fsm_sva u_fsm_sva (
    .clk    (clk),
    .rst    (rst),
    .state  (state),
    .tail   (tail),
    .accept (accept),
    .rsp    (rsp)
);

// File: tests/tb_mmio_uart_rx.sv
`timescale 1ns/1ps

module tb_mmio_uart_rx;
    import mmio_uart_rx_pkg::*;

    localparam int CLKS_PER_BIT   = 8;
    localparam int TIMEOUT_CYCLES = 200;

    logic        clk;
    logic        rst;
    logic        uart_rx;
    mmio_cmd_t   cmd;
    logic        ready;
    mmio_rsp_t   rsp;

    // Reference copy of the ring buffer with one entry per byte position
    rx_byte_t    model_bytes [0:1023];
    logic        model_set   [0:1023];
    int          model_tail;
    int          model_wraps;
    int          value_errors;
    int          other_errors;
    rx_word_t    read_data;

    mmio_uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uut (
        .clk     (clk),
        .rst     (rst),
        .uart_rx (uart_rx),
        .cmd     (cmd),
        .ready   (ready),
        .rsp     (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Model and compare helpers
    // ----------------------------------------
    function automatic rx_word_t model_word(input int idx, input logic want_mask);
        rx_word_t w;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            if (model_set[idx*4+k]) begin
                w[k*8 +: 8] = want_mask ? 8'hff : model_bytes[idx*4+k];
            end
        end
        return w;
    endfunction

    function automatic logic [31:0] word_addr(input int idx);
        return 32'(idx) << 2;
    endfunction

    // Lanes never written hold unknown RAM contents, so only set lanes are compared
    task automatic check_word(input string name, input rx_word_t got, input int idx);
        rx_word_t mask;
        mask = model_word(idx, 1'b1);
        if ((got & mask) !== (model_word(idx, 1'b0) & mask)) begin
            $display("[FAIL] %s: got %08h, expected %08h (lanes %08h)",
                     name, got, model_word(idx, 1'b0), mask);
            value_errors++;
        end
    endtask

    task automatic check_tail(input string name, input rx_tail_t got, input rx_tail_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %03h, expected %03h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_count(input string name, input rx_word_t got, input rx_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %08h, expected %08h", name, got, exp);
            value_errors++;
        end
    endtask

    // ----------------------------------------
    // Line and bus drivers
    // ----------------------------------------
    task automatic send_byte(input rx_byte_t data, input logic bad_stop);
        logic [9:0] frame;
        frame = {~bad_stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        @(posedge clk);
        uart_rx <= 1'b1;
        repeat (2 * CLKS_PER_BIT - 1) @(posedge clk);
        if (!bad_stop) begin
            model_bytes[model_tail] = data;
            model_set[model_tail]   = 1'b1;
            model_tail = (model_tail + 1) % 1024;
            if (model_tail == 0) begin
                model_wraps++;
            end
        end
    endtask

    task automatic bus_read(input logic [31:0] addr, output rx_word_t data);
        int   waited;
        logic done;
        data = '0;
        waited = 0;
        done = 1'b0;
        @(posedge clk);
        cmd <= '{start: 1'b1, addr: addr};
        // Ready seen mid-cycle means the command is taken at the next edge
        while (!done && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            done = ready;
            waited++;
        end
        @(posedge clk);
        cmd <= '{start: 1'b0, addr: addr};
        if (!done) begin
            $display("Timeout: ready never rose for a read of address %08h", addr);
            other_errors++;
            return;
        end
        waited = 0;
        done = 1'b0;
        while (!done && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            done = rsp.rdata_valid;
            waited++;
        end
        if (done) begin
            data = rsp.rdata;
        end else begin
            $display("Timeout: no read data came back for address %08h", addr);
            other_errors++;
        end
    endtask

    task automatic verify_tail_and_count(input string when);
        bus_read(RX_TAIL_ADDR, read_data);
        check_tail({"tail ", when}, read_data[9:0], rx_tail_t'(model_tail));
        bus_read(RX_COUNT_ADDR, read_data);
        check_count({"wrap count ", when}, read_data, rx_word_t'(model_wraps));
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_state();
        @(negedge clk);
        if (ready !== 1'b1) begin
            $display("[FAIL] ready: got %h, expected 1", ready);
            value_errors++;
        end
        verify_tail_and_count("after reset");
    endtask

    task automatic test_four_bytes();
        for (int k = 0; k < 4; k++) begin
            send_byte(rx_byte_t'($urandom), 1'b0);
        end
        bus_read(word_addr(0), read_data);
        check_word("word 0 after four bytes", read_data, 0);
        verify_tail_and_count("after four bytes");
    endtask

    task automatic test_bad_stop();
        send_byte(rx_byte_t'($urandom), 1'b1);
        verify_tail_and_count("after bad stop");
        bus_read(word_addr(0), read_data);
        check_word("word 0 after bad stop", read_data, 0);
        send_byte(rx_byte_t'($urandom), 1'b0);
        bus_read(word_addr(1), read_data);
        check_word("word 1 after good byte", read_data, 1);
        verify_tail_and_count("after good byte");
    endtask

    task automatic test_read_during_byte();
        // A read takes three cycles, so three offsets put the stored byte on
        // the command cycle, on the read wait and on the idle cycle
        for (int offset = 0; offset < 3; offset++) begin
            fork
                send_byte(rx_byte_t'($urandom), 1'b0);
                begin
                    repeat (4 * CLKS_PER_BIT + offset) @(posedge clk);
                    bus_read(word_addr(1), read_data);
                    check_word("word 1 before byte lands", read_data, 1);
                    // Back-to-back reads run across the cycle the byte is stored
                    for (int n = 0; n < 20; n++) begin
                        bus_read(word_addr(0), read_data);
                        check_word("word 0 while byte lands", read_data, 0);
                    end
                end
            join
            bus_read(word_addr(1), read_data);
            check_word("word 1 after byte lands", read_data, 1);
            verify_tail_and_count("after collision");
        end
    endtask

    task automatic test_wrap();
        int remaining;
        remaining = 1024 - model_tail;
        repeat (remaining) send_byte(rx_byte_t'($urandom), 1'b0);
        bus_read(RX_TAIL_ADDR, read_data);
        check_tail("tail after wrap", read_data[9:0], 10'd0);
        bus_read(RX_COUNT_ADDR, read_data);
        check_count("wrap count after wrap", read_data, 32'd1);
        bus_read(word_addr(255), read_data);
        check_word("word 255 after wrap", read_data, 255);
        for (int k = 0; k < 4; k++) begin
            send_byte(rx_byte_t'($urandom), 1'b0);
            bus_read(word_addr(0), read_data);
            check_word("word 0 overwrite", read_data, 0);
        end
        verify_tail_and_count("after overwrite");
    endtask

    initial begin
        rst     <= 1'b1;
        uart_rx <= 1'b1;
        cmd     <= '0;
        value_errors = 0;
        other_errors = 0;
        model_tail   = 0;
        model_wraps  = 0;
        for (int i = 0; i < 1024; i++) begin
            model_set[i] = 1'b0;
        end
        void'($urandom(32'h1a20));
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        test_reset_state();
        test_four_bytes();
        test_bad_stop();
        test_read_during_byte();
        test_wrap();

        $display("Finished with %0d value errors and %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: mmio_uart_rx.f
+incdir+include
design/mmio_uart_rx_pkg.sv
design/baud_timer.sv
design/uart_rx_deserializer.sv
design/rx_buffer_ram.sv
design/rx_buffer_fsm.sv
design/mmio_uart_rx.sv
tests/rx_buffer_fsm_sva.sv
tests/tb_mmio_uart_rx.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_mmio_uart_rx \
    -f mmio_uart_rx.f \
    -o sim_mmio_uart_rx

status=0
./obj_dir/sim_mmio_uart_rx > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TESTS FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
